/* spy_params.svh */
`ifndef SPY_PARAMS_SVH
`define SPY_PARAMS_SVH

// sizing of the spy buffer bank

`define SPY_NUM_BUF 4   // buffers in the bank
`define SPY_ADDR_W  6   // 64 words per buffer
`define SPY_DATA_W  32  // monitor and register word
`define SPY_SEL_W   2   // buffer select field

`endif

/* spy_pkg.sv */
`include "spy_params.svh"

package spy_pkg;

   typedef enum logic [1:0]
   {
      SPY_OP_READ  = 2'd0,  // read spy memory word
      SPY_OP_WRITE = 2'd1,  // write spy memory word
      SPY_OP_PTR   = 2'd2   // read capture pointer
   } spy_op_e;

   typedef enum logic [1:0]
   {
      DEC_IDLE     = 2'd0,  // waiting for req
      DEC_BUSY     = 2'd1,  // access issued, waiting for ack
      DEC_WAIT_REL = 2'd2   // waiting for req to drop
   } spy_dec_state_e;

   typedef struct packed
   {
      spy_op_e                  op;
      logic [`SPY_SEL_W-1:0]    sel;   // target buffer
      logic [`SPY_ADDR_W-1:0]   addr;
      logic [`SPY_DATA_W-1:0]   wdata; // ignored unless write
   } spy_cmd_t;

   typedef struct packed
   {
      logic                     vld;   // single-cycle strobe
      spy_op_e                  op;
      logic [`SPY_SEL_W-1:0]    sel;
      logic [`SPY_ADDR_W-1:0]   addr;
      logic [`SPY_DATA_W-1:0]   data;
   } spy_access_t;

   typedef struct packed
   {
      logic                     vld;   // beat carries data
      logic [`SPY_DATA_W-1:0]   data;
   } spy_mon_t;

endpackage

/* spy_cmd_decode.sv */
`timescale 1ns/1ps

module spy_cmd_decode
(
   input  logic                 spy_clock,
   input  logic                 axi_reset_n,
   input  logic                 req_i,        // four-phase request
   input  spy_pkg::spy_cmd_t    cmd_i,        // stable while req_i high
   input  logic                 init_busy_i,  // sweep running, hold off
   input  logic                 ack_i,        // ack level from result stage
   output spy_pkg::spy_access_t access_o,     // one-cycle decoded access
   output logic                 done_o        // access valid, one cycle later
);

   spy_pkg::spy_dec_state_e state_q;
   spy_pkg::spy_dec_state_e state_d;
   logic                    accept;

   // only one command in flight, none during a sweep
   assign accept = (state_q == spy_pkg::DEC_IDLE) && req_i && !init_busy_i;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         spy_pkg::DEC_IDLE:
         begin
            if (accept)
            begin
               state_d = spy_pkg::DEC_BUSY;  // access goes out this edge
            end
         end
         spy_pkg::DEC_BUSY:
         begin
            if (ack_i)
            begin
               state_d = spy_pkg::DEC_WAIT_REL;
            end
         end
         spy_pkg::DEC_WAIT_REL:
         begin
            // held req must not issue a second access
            if (!req_i)
            begin
               state_d = spy_pkg::DEC_IDLE;  // ack drops on this same edge
            end
         end
         default:
         begin
            state_d = spy_pkg::DEC_IDLE;
         end
      endcase
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         state_q      <= spy_pkg::DEC_IDLE;
         access_o.vld <= 1'b0;
         done_o       <= 1'b0;
      end
      else
      begin
         state_q      <= state_d;
         access_o.vld <= accept;        // pulse, pipeline edge 1
         done_o       <= access_o.vld;  // lines up with buffer read word
         if (accept)
         begin
            access_o.op   <= cmd_i.op;     // payload, no reset
            access_o.sel  <= cmd_i.sel;
            access_o.addr <= cmd_i.addr;
            access_o.data <= cmd_i.wdata;
         end
      end
   end

endmodule

/* spy_init_sweep.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module spy_init_sweep
(
   input  logic                   spy_clock,
   input  logic                   axi_reset_n,
   input  logic                   init_spy_mem_i,  // sweep starts on release
   output logic                   sweep_we_o,      // zero-write strobe
   output logic [`SPY_ADDR_W-1:0] sweep_addr_o,
   output logic                   init_busy_o
);

   logic busy_q;

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         busy_q       <= 1'b1;  // clear memories after reset
         sweep_addr_o <= '0;
      end
      else if (init_spy_mem_i)
      begin
         busy_q       <= 1'b1;  // rearm, count held at zero
         sweep_addr_o <= '0;
      end
      else if (busy_q)
      begin
         sweep_addr_o <= sweep_addr_o + 1'b1;  // wraps back to 0
         if (sweep_addr_o == '1)
         begin
            busy_q <= 1'b0;  // last address written
         end
      end
   end

   assign sweep_we_o  = busy_q;
   // request pending counts as busy so decode stops at once
   assign init_busy_o = busy_q | init_spy_mem_i;

endmodule

/* spy_buffer_mem.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module spy_buffer_mem
#(
   parameter int BUF_INDEX = 0  // select value of this buffer
)
(
   input  logic                   spy_clock,
   input  logic                   axi_reset_n,
   input  spy_pkg::spy_mon_t      mon_i,         // capture stream
   input  logic                   freeze_i,      // stops capture
   input  spy_pkg::spy_access_t   access_i,      // decoded register access
   input  logic                   sweep_we_i,
   input  logic [`SPY_ADDR_W-1:0] sweep_addr_i,
   output logic [`SPY_DATA_W-1:0] rd_word_o      // zero unless read of this buffer
);

   localparam logic [`SPY_SEL_W-1:0] SEL_ID = `SPY_SEL_W'(BUF_INDEX);
   localparam int DEPTH = 2 ** `SPY_ADDR_W;

   logic [`SPY_DATA_W-1:0] mem [DEPTH];
   logic [`SPY_ADDR_W-1:0] wr_ptr_q;    // next capture address
   logic                   hit;
   logic                   reg_wr;
   logic                   reg_rd;
   logic                   ptr_rd;
   logic                   cap_wr;

   assign hit    = access_i.vld && (access_i.sel == SEL_ID);
   assign reg_wr = hit && (access_i.op == spy_pkg::SPY_OP_WRITE);
   assign reg_rd = hit && (access_i.op == spy_pkg::SPY_OP_READ);
   assign ptr_rd = hit && (access_i.op == spy_pkg::SPY_OP_PTR);
   assign cap_wr = mon_i.vld && !freeze_i;  // no back-pressure

   // single write port, sweep > register > capture
   always_ff @(posedge spy_clock)
   begin
      if (sweep_we_i)
      begin
         mem[sweep_addr_i] <= '0;
      end
      else if (reg_wr)
      begin
         mem[access_i.addr] <= access_i.data;  // capture beat dropped
      end
      else if (cap_wr)
      begin
         mem[wr_ptr_q] <= mon_i.data;
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         wr_ptr_q <= '0;
      end
      else if (sweep_we_i)
      begin
         wr_ptr_q <= '0;  // sweep restarts capture at 0
      end
      else if (cap_wr && !reg_wr)
      begin
         wr_ptr_q <= wr_ptr_q + 1'b1;  // circular, wraps at 64
      end
   end

   // pipeline edge 2, only the selected buffer drives non-zero
   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         rd_word_o <= '0;
      end
      else if (reg_rd)
      begin
         rd_word_o <= mem[access_i.addr];
      end
      else if (ptr_rd)
      begin
         rd_word_o <= {{(`SPY_DATA_W-`SPY_ADDR_W){1'b0}}, wr_ptr_q};
      end
      else
      begin
         rd_word_o <= '0;  // writes and misses return zero
      end
   end

endmodule

/* spy_result.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module spy_result
(
   input  logic                   spy_clock,
   input  logic                   axi_reset_n,
   input  logic                   done_i,                      // read words valid now
   input  logic                   req_i,                       // release detection
   input  logic [`SPY_DATA_W-1:0] buf_words_i [`SPY_NUM_BUF],  // one per buffer
   output logic [`SPY_DATA_W-1:0] rdata_o,
   output logic                   ack_o
);

   logic [`SPY_DATA_W-1:0] merged;

   // unselected buffers are zero, so OR is the mux
   always_comb
   begin
      merged = '0;
      for (int i = 0; i < `SPY_NUM_BUF; i++)
      begin
         merged = merged | buf_words_i[i];
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         ack_o   <= 1'b0;
         rdata_o <= '0;
      end
      else if (done_i)
      begin
         ack_o   <= 1'b1;    // pipeline edge 3
         rdata_o <= merged;
      end
      else if (!req_i)
      begin
         ack_o   <= 1'b0;    // falls after req seen low
         rdata_o <= '0;      // data only valid alongside ack
      end
   end

endmodule

/* fm_spy_top.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module fm_spy_top
(
   input  logic                   spy_clock,
   input  logic                   axi_reset_n,
   input  logic                   req_i,
   input  spy_pkg::spy_cmd_t      cmd_i,
   input  spy_pkg::spy_mon_t      mon_i [`SPY_NUM_BUF],  // one stream per buffer
   input  logic [`SPY_NUM_BUF-1:0] freeze_i,
   input  logic                   init_spy_mem_i,
   output logic                   ack_o,
   output logic [`SPY_DATA_W-1:0] rdata_o,
   output logic                   init_busy_o
);

   spy_pkg::spy_access_t   access;     // broadcast to all buffers
   logic                   done;
   logic                   sweep_we;
   logic [`SPY_ADDR_W-1:0] sweep_addr;
   logic [`SPY_DATA_W-1:0] buf_words [`SPY_NUM_BUF];

   spy_cmd_decode u_decode
   (
      .spy_clock   (spy_clock),
      .axi_reset_n (axi_reset_n),
      .req_i       (req_i),
      .cmd_i       (cmd_i),
      .init_busy_i (init_busy_o),  // holds off register access
      .ack_i       (ack_o),
      .access_o    (access),
      .done_o      (done)
   );

   spy_init_sweep u_sweep
   (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .init_spy_mem_i (init_spy_mem_i),
      .sweep_we_o     (sweep_we),
      .sweep_addr_o   (sweep_addr),
      .init_busy_o    (init_busy_o)
   );

   for (genvar i = 0; i < `SPY_NUM_BUF; i++)
   begin : g_buf
      spy_buffer_mem #(.BUF_INDEX(i)) u_buf
      (
         .spy_clock    (spy_clock),
         .axi_reset_n  (axi_reset_n),
         .mon_i        (mon_i[i]),
         .freeze_i     (freeze_i[i]),
         .access_i     (access),
         .sweep_we_i   (sweep_we),    // same sweep for every buffer
         .sweep_addr_i (sweep_addr),
         .rd_word_o    (buf_words[i])
      );
   end

   spy_result u_result
   (
      .spy_clock   (spy_clock),
      .axi_reset_n (axi_reset_n),
      .done_i      (done),
      .req_i       (req_i),
      .buf_words_i (buf_words),
      .rdata_o     (rdata_o),
      .ack_o       (ack_o)
   );

endmodule

/* tb_fm_spy_assert.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module tb_fm_spy_assert
(
   input logic                   spy_clock,
   input logic                   axi_reset_n,
   input logic                   req_i,
   input logic                   ack_i,        // top ack_o
   input logic [`SPY_DATA_W-1:0] rdata_i,      // top rdata_o
   input logic                   init_busy_i   // top init_busy_o
);

   ack_needs_req: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      $rose(ack_i) |-> $past(req_i))
      else $error("ack_o rose with no request pending");

   data_zero_without_ack: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      !ack_i |-> (rdata_i == '0))
      else $error("rdata_o non-zero while ack_o low");

   // accept edge sits three edges before the sampled rise
   no_accept_in_sweep: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      $rose(ack_i) |-> !$past(init_busy_i, 3))
      else $error("request accepted while init sweep busy");

endmodule

bind fm_spy_top tb_fm_spy_assert u_assert
(
   .spy_clock   (spy_clock),
   .axi_reset_n (axi_reset_n),
   .req_i       (req_i),
   .ack_i       (ack_o),
   .rdata_i     (rdata_o),
   .init_busy_i (init_busy_o)
);

/* tb_fm_spy.sv */
`timescale 1ns/1ps
`include "spy_params.svh"

module tb_fm_spy;

   localparam int CLK_PERIOD = 8;
   localparam int NBUF       = `SPY_NUM_BUF;
   localparam int DEPTH      = 2 ** `SPY_ADDR_W;
   localparam int ACK_LIMIT  = DEPTH + 32;   // longest wait, behind a full sweep
   localparam int ACC_LEN    = 8;            // cycles per handshake incl gaps
   localparam int CAP_BEATS  = 40;
   localparam int SCAN_LEN   = NBUF * (DEPTH + 1) * ACC_LEN;  // read back all buffers
   localparam int RUN_LEN    = DEPTH + SCAN_LEN                // reset clear
                               + 2 * NBUF * 8 * ACC_LEN        // write and read
                               + 2 * CAP_BEATS + SCAN_LEN / NBUF
                               + 24 + SCAN_LEN / NBUF          // frozen buffer
                               + ACK_LIMIT + SCAN_LEN          // init request
                               + 4 * ACC_LEN + 32              // held request
                               + 500;                          // margin

   logic                    spy_clock;
   logic                    axi_reset_n;
   logic                    req_i;
   spy_pkg::spy_cmd_t       cmd_i;
   spy_pkg::spy_mon_t       mon_i [NBUF];
   logic [NBUF-1:0]         freeze_i;
   logic                    init_spy_mem_i;
   logic                    ack_o;
   logic [`SPY_DATA_W-1:0]  rdata_o;
   logic                    init_busy_o;

   integer                  seed;
   int                      errors;
   int                      checks;
   int                      access_count = 0;    // decoded access pulses seen
   logic [`SPY_DATA_W-1:0]  model [NBUF][DEPTH]; // expected memory contents
   logic [`SPY_ADDR_W-1:0]  ptr_model [NBUF];    // expected capture pointers

   fm_spy_top DUT
   (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .req_i          (req_i),
      .cmd_i          (cmd_i),
      .mon_i          (mon_i),
      .freeze_i       (freeze_i),
      .init_spy_mem_i (init_spy_mem_i),
      .ack_o          (ack_o),
      .rdata_o        (rdata_o),
      .init_busy_o    (init_busy_o)
   );

   initial
   begin
      spy_clock = 1'b0;
      forever #(CLK_PERIOD / 2) spy_clock = ~spy_clock;
   end

   always @(negedge spy_clock)
   begin
      if (DUT.access.vld === 1'b1)
      begin
         access_count++;  // one-cycle strobe, seen once
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_at_start);
      if (errors == errs_at_start)
      begin
         $display("%s: ok", name);
      end
      else
      begin
         $display("%s: %0d mismatches", name, errors - errs_at_start);
      end
   endtask

   // full four-phase cycle, hold keeps req high past ack
   task automatic run_access
   (
      input  spy_pkg::spy_op_e       op,
      input  logic [`SPY_SEL_W-1:0]  sel,
      input  logic [`SPY_ADDR_W-1:0] addr,
      input  logic [`SPY_DATA_W-1:0] wdata,
      input  int                     hold,
      output logic [`SPY_DATA_W-1:0] rdata,
      output int                     latency
   );
      int rel_cnt;
      @(negedge spy_clock);
      cmd_i.op    = op;
      cmd_i.sel   = sel;
      cmd_i.addr  = addr;
      cmd_i.wdata = wdata;
      req_i       = 1'b1;
      latency     = 0;
      while (ack_o !== 1'b1 && latency < ACK_LIMIT)
      begin
         @(negedge spy_clock);
         latency++;  // rising edges since req raised
      end
      rdata = rdata_o;
      if (ack_o !== 1'b1)
      begin
         errors++;
         $display("no ack for %s to buffer %0d address %0d within %0d cycles",
                  op.name(), sel, addr, ACK_LIMIT);
      end
      repeat (hold)
      begin
         @(negedge spy_clock);
         check_value("rdata_o while req held", rdata_o, rdata);
      end
      req_i   = 1'b0;
      rel_cnt = 0;
      do
      begin
         @(negedge spy_clock);
         rel_cnt++;
      end
      while (ack_o !== 1'b0 && rel_cnt < ACK_LIMIT);
      check_value("ack_o release cycles", rel_cnt, 1);
      @(negedge spy_clock);  // decode leaves its release state
   endtask

   task automatic verify_buffer(input int b);
      logic [`SPY_DATA_W-1:0] got;
      int                     lat;
      for (int a = 0; a < DEPTH; a++)
      begin
         run_access(spy_pkg::SPY_OP_READ, `SPY_SEL_W'(b), `SPY_ADDR_W'(a), '0, 0, got, lat);
         check_value($sformatf("rdata_o buf %0d addr %0d", b, a), got, model[b][a]);
      end
      run_access(spy_pkg::SPY_OP_PTR, `SPY_SEL_W'(b), '0, '0, 0, got, lat);
      check_value($sformatf("rdata_o ptr buf %0d", b), got, `SPY_DATA_W'(ptr_model[b]));
   endtask

   task automatic clear_after_reset;
      int n;
      int e0;
      e0 = errors;
      check_value("init_busy_o", init_busy_o, 1);  // sweep runs out of reset
      check_value("ack_o", ack_o, 0);
      n = 0;
      while (init_busy_o !== 1'b0 && n < ACK_LIMIT)
      begin
         @(negedge spy_clock);
         n++;
      end
      check_value("init sweep cycles", n, DEPTH);
      for (int b = 0; b < NBUF; b++)
      begin
         verify_buffer(b);
      end
      report_test("reset_clear", e0);
   endtask

   task automatic write_read_back;
      logic [`SPY_DATA_W-1:0] data;
      logic [`SPY_DATA_W-1:0] got;
      logic [`SPY_ADDR_W-1:0] addr;
      int                     lat;
      int                     e0;
      e0 = errors;
      for (int b = 0; b < NBUF; b++)
      begin
         for (int k = 0; k < 8; k++)
         begin
            addr = `SPY_ADDR_W'(k * 9 + 2);  // same spread in every buffer
            data = $random(seed);
            run_access(spy_pkg::SPY_OP_WRITE, `SPY_SEL_W'(b), addr, data, 0, got, lat);
            check_value("rdata_o on write", got, '0);
            model[b][addr] = data;
         end
      end
      for (int b = 0; b < NBUF; b++)
      begin
         for (int k = 0; k < 8; k++)
         begin
            addr = `SPY_ADDR_W'(k * 9 + 2);
            run_access(spy_pkg::SPY_OP_READ, `SPY_SEL_W'(b), addr, '0, 0, got, lat);
            check_value($sformatf("rdata_o buf %0d addr %0d", b, addr), got, model[b][addr]);
            check_value("ack_o latency", lat, 3);
         end
      end
      report_test("write_read", e0);
   endtask

   task automatic capture_stream;
      logic [`SPY_DATA_W-1:0] data;
      logic                   vld;
      int                     n;
      int                     i;
      int                     e0;
      e0 = errors;
      @(negedge spy_clock);
      freeze_i = '1;
      @(negedge spy_clock);
      freeze_i[1] = 1'b0;  // only buffer 1 records
      n = 0;
      i = 0;
      while (n < CAP_BEATS)
      begin
         @(negedge spy_clock);
         data          = $random(seed);
         vld           = (i % 4) != 3;  // every fourth beat idle
         mon_i[1].vld  = vld;
         mon_i[1].data = data;
         if (vld)
         begin
            model[1][ptr_model[1]] = data;
            ptr_model[1]           = ptr_model[1] + 1'b1;
            n++;
         end
         i++;
      end
      @(negedge spy_clock);
      mon_i[1].vld = 1'b0;
      freeze_i[1]  = 1'b1;
      verify_buffer(1);
      report_test("capture", e0);
   endtask

   task automatic frozen_keeps_contents;
      int e0;
      e0 = errors;
      repeat (20)
      begin
         @(negedge spy_clock);
         mon_i[3].vld  = 1'b1;  // stream into a frozen buffer
         mon_i[3].data = $random(seed);
      end
      @(negedge spy_clock);
      mon_i[3].vld = 1'b0;
      verify_buffer(3);
      report_test("frozen_buffer", e0);
   endtask

   task automatic init_request_sweep;
      logic [`SPY_DATA_W-1:0] got;
      int                     lat;
      int                     e0;
      e0 = errors;
      @(negedge spy_clock);
      init_spy_mem_i = 1'b1;
      repeat (2) @(negedge spy_clock);
      init_spy_mem_i = 1'b0;  // sweep starts on release
      check_value("init_busy_o", init_busy_o, 1);
      for (int b = 0; b < NBUF; b++)
      begin
         ptr_model[b] = '0;
         for (int a = 0; a < DEPTH; a++)
         begin
            model[b][a] = '0;
         end
      end
      run_access(spy_pkg::SPY_OP_READ, 2'd0, 6'd2, '0, 0, got, lat);  // lands mid sweep
      check_value("rdata_o buf 0 addr 2", got, '0);
      if (lat < DEPTH)
      begin
         errors++;
         $display("read during init sweep was answered after %0d cycles, before the sweep ended",
                  lat);
      end
      for (int b = 0; b < NBUF; b++)
      begin
         verify_buffer(b);
      end
      report_test("init_request", e0);
   endtask

   task automatic held_request_once;
      logic [`SPY_DATA_W-1:0] data;
      logic [`SPY_DATA_W-1:0] got;
      int                     lat;
      int                     count0;
      int                     e0;
      e0     = errors;
      data   = $random(seed);
      count0 = access_count;
      run_access(spy_pkg::SPY_OP_WRITE, 2'd0, 6'd17, data, 5, got, lat);
      model[0][17] = data;
      check_value("access.vld pulses on held write", access_count - count0, 1);
      count0 = access_count;
      run_access(spy_pkg::SPY_OP_READ, 2'd0, 6'd17, '0, 5, got, lat);
      check_value("rdata_o held read", got, data);
      check_value("access.vld pulses on held read", access_count - count0, 1);
      repeat (3)
      begin
         @(negedge spy_clock);
         check_value("rdata_o after ack", rdata_o, '0);
      end
      report_test("held_request", e0);
   endtask

   initial
   begin
      seed           = 32'h159f_f0a1;
      errors         = 0;
      checks         = 0;
      axi_reset_n    = 1'b0;
      req_i          = 1'b0;
      cmd_i          = '0;
      freeze_i       = '1;
      init_spy_mem_i = 1'b0;
      for (int b = 0; b < NBUF; b++)
      begin
         mon_i[b]     = '0;
         ptr_model[b] = '0;
         for (int a = 0; a < DEPTH; a++)
         begin
            model[b][a] = '0;
         end
      end
      repeat (3) @(posedge spy_clock);
      @(negedge spy_clock);
      axi_reset_n = 1'b1;
      clear_after_reset();
      write_read_back();
      capture_stream();
      frozen_keeps_contents();
      init_request_sweep();
      held_request_once();
      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   initial
   begin
      #(RUN_LEN * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the tests did not complete", RUN_LEN);
      $display("Test failed");
      $finish;
   end

endmodule

/* build.f */
+incdir+.
spy_pkg.sv
spy_cmd_decode.sv
spy_init_sweep.sv
spy_buffer_mem.sv
spy_result.sv
fm_spy_top.sv
tb_fm_spy_assert.sv
tb_fm_spy.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_fm_spy
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
